/* axi_mem_bridge.f */
src/axi_mem_pkg.sv
src/ax_arbiter.sv
src/meta_fifo.sv
src/mem_bank_split.sv
src/resp_router.sv
src/axi_mem_bridge.sv
bench/axi_mem_checker.sv
bench/axi_mem_assertions.sv
bench/tb_axi_mem_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axi_mem_bridge \
  -f axi_mem_bridge.f -o vsim_tb > build.log 2>&1 \
  && ./obj_dir/vsim_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
! grep -q "SOME TESTS FAILED" sim.log && grep -q "ALL TESTS PASSED" sim.log \
  || { echo "simulation reported failure"; exit 1; }

/* bench/tb_axi_mem_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_bridge;

  localparam int Timeout = 300;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    busy;
  logic                    ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic                    b_valid, b_ready, r_valid, r_ready;
  axi_mem_pkg::ar_chan_t   ar;
  axi_mem_pkg::aw_chan_t   aw;
  axi_mem_pkg::w_chan_t    w;
  axi_mem_pkg::b_chan_t    b;
  axi_mem_pkg::r_chan_t    r;
  logic                    [1:0] bank_req, bank_gnt, bank_we, bank_rvalid;
  axi_mem_pkg::addr_t      [1:0] bank_addr;
  axi_mem_pkg::bank_data_t [1:0] bank_wdata, bank_rdata;
  axi_mem_pkg::bank_strb_t [1:0] bank_strb;
  axi_mem_pkg::bank_data_t bank_mem [2][256];
  integer                  seed = 30035;
  logic                    stall_en = 1'b0;
  logic                    timed_out = 1'b0;
  int                      chk_errors, chk_pending;
  int                      tb_errors = 0;

  always #2 clk_i = ~clk_i;

  axi_mem_bridge dut_i (
    .clk_i (clk_i), .rst_ni (rst_ni), .busy_o (busy),
    .ar_valid_i (ar_valid), .ar_i (ar), .ar_ready_o (ar_ready),
    .aw_valid_i (aw_valid), .aw_i (aw), .aw_ready_o (aw_ready),
    .w_valid_i (w_valid), .w_i (w), .w_ready_o (w_ready),
    .b_valid_o (b_valid), .b_o (b), .b_ready_i (b_ready),
    .r_valid_o (r_valid), .r_o (r), .r_ready_i (r_ready),
    .bank_req_o (bank_req), .bank_gnt_i (bank_gnt), .bank_addr_o (bank_addr),
    .bank_wdata_o (bank_wdata), .bank_strb_o (bank_strb), .bank_we_o (bank_we),
    .bank_rvalid_i (bank_rvalid), .bank_rdata_i (bank_rdata)
  );

  axi_mem_checker checker_i (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .ar_valid_i (ar_valid), .ar_i (ar), .ar_ready_i (ar_ready),
    .aw_valid_i (aw_valid), .aw_i (aw), .aw_ready_i (aw_ready), .w_i (w),
    .b_valid_i (b_valid), .b_i (b), .b_ready_i (b_ready),
    .r_valid_i (r_valid), .r_i (r), .r_ready_i (r_ready),
    .errors_o (chk_errors), .pending_o (chk_pending)
  );

  function automatic axi_mem_pkg::bank_data_t pattern_at(input axi_mem_pkg::addr_t a);
    return {a[7:0] ^ 8'h5a, a[15:8] ^ 8'hc3};
  endfunction

  initial begin
    for (int bk = 0; bk < 2; bk++) begin
      for (int i = 0; i < 256; i++) bank_mem[bk][i] = pattern_at(axi_mem_pkg::addr_t'(i*4 + bk*2));
    end
  end

  // Two 16-bit banks that answer one cycle after each grant
  always @(posedge clk_i) begin
    logic [7:0] idx;
    for (int bk = 0; bk < 2; bk++) begin
      idx = bank_addr[bk][9:2];
      bank_rvalid[bk] <= bank_req[bk] & bank_gnt[bk];
      bank_gnt[bk]    <= stall_en ? (($random(seed) % 3) != 0) : 1'b1;
      if (bank_req[bk] && bank_gnt[bk]) begin
        bank_rdata[bk] <= bank_mem[bk][idx];
        for (int k = 0; k < 2; k++) begin
          if (bank_we[bk] && bank_strb[bk][k]) bank_mem[bk][idx][k*8 +: 8] <= bank_wdata[bk][k*8 +: 8];
        end
      end
    end
  end

  always @(posedge clk_i) begin
    b_ready <= stall_en ? (($random(seed) % 2) == 0) : 1'b1;
    r_ready <= stall_en ? (($random(seed) % 2) == 0) : 1'b1;
  end

  task automatic note_timeout(input string what);
    $display("timeout while waiting for %s", what);
    timed_out = 1'b1;
    tb_errors++;
  endtask

  // Drive AR and/or AW+W together and hold each until it is accepted
  task automatic issue(input logic do_rd, input axi_mem_pkg::id_t rd_id,
                       input axi_mem_pkg::addr_t rd_addr, input logic do_wr,
                       input axi_mem_pkg::id_t wr_id, input axi_mem_pkg::addr_t wr_addr,
                       input axi_mem_pkg::data_t data, input axi_mem_pkg::strb_t strb);
    logic rd_left;
    logic wr_left;
    int   t;
    if (timed_out) return;
    rd_left = do_rd;
    wr_left = do_wr;
    t = 0;
    @(posedge clk_i);
    ar_valid <= do_rd;
    ar       <= '{id: rd_id, addr: rd_addr};
    aw_valid <= do_wr;
    w_valid  <= do_wr;
    aw       <= '{id: wr_id, addr: wr_addr};
    w        <= '{data: data, strb: strb};
    while (rd_left || wr_left) begin
      if (t == Timeout) begin
        note_timeout("a request handshake");
        return;
      end
      t++;
      @(negedge clk_i);
      if (ar_valid && ar_ready) rd_left = 1'b0;
      if (aw_valid && aw_ready && w_valid && w_ready) wr_left = 1'b0;
      @(posedge clk_i);
      if (!rd_left) ar_valid <= 1'b0;
      if (!wr_left) begin
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
      end
    end
  endtask

  task automatic wait_drain();
    logic busy_seen;
    logic resp_seen;
    int   t;
    if (timed_out) return;
    busy_seen = 1'b1;
    resp_seen = 1'b0;
    t = 0;
    while (busy_seen || chk_pending != 0) begin
      if (t == Timeout) begin
        note_timeout("outstanding responses to drain");
        return;
      end
      t++;
      @(negedge clk_i);
      busy_seen = busy;
      resp_seen = b_valid | r_valid;
      @(posedge clk_i);
    end
    if (resp_seen) begin
      $display("response valid still high after traffic drained");
      tb_errors++;
    end
  endtask

  initial begin
    axi_mem_pkg::addr_t a;
    int                 k;
    rst_ni <= 1'b0;
    ar_valid <= 1'b0;
    aw_valid <= 1'b0;
    w_valid <= 1'b0;
    ar <= '0;
    aw <= '0;
    w <= '0;
    b_ready <= 1'b1;
    r_ready <= 1'b1;
    bank_gnt <= 2'b11;
    bank_rvalid <= 2'b00;
    bank_rdata <= '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (busy || b_valid || r_valid) begin
      $display("busy or a response valid is high right after reset");
      tb_errors++;
    end
    // Write then read back the same word
    issue(1'b0, 4'h0, '0, 1'b1, 4'h3, 16'h0010, 32'hdeadbeef, 4'hf);
    wait_drain();
    issue(1'b1, 4'h7, 16'h0010, 1'b0, 4'h0, '0, '0, '0);
    wait_drain();
    // Partial strobes across both banks
    issue(1'b0, 4'h0, '0, 1'b1, 4'h1, 16'h0040, 32'h11223344, 4'hf);
    issue(1'b0, 4'h0, '0, 1'b1, 4'h2, 16'h0040, 32'haabbccdd, 4'b0110);
    issue(1'b1, 4'h4, 16'h0040, 1'b0, 4'h0, '0, '0, '0);
    issue(1'b0, 4'h0, '0, 1'b1, 4'h5, 16'h0042, 32'h99887766, 4'b1001);
    issue(1'b1, 4'h6, 16'h0040, 1'b0, 4'h0, '0, '0, '0);
    wait_drain();
    // AR and AW+W held together until both get through
    for (int i = 0; i < 6; i++) begin
      issue(1'b1, 4'(i), 16'h0080, 1'b1, 4'(i + 8), 16'h0084, 32'(i) * 32'h01010101, 4'hf);
    end
    wait_drain();
    // Random mix with stalls on B, R and bank grants
    stall_en <= 1'b1;
    for (int n = 0; n < 40; n++) begin
      k = $unsigned($random(seed)) % 32;
      a = axi_mem_pkg::addr_t'(16'h0200 + k * 4);
      if ($random(seed) % 2 == 0) begin
        issue(1'b1, 4'($random(seed)), a, 1'b0, 4'h0, '0, '0, '0);
      end else begin
        issue(1'b0, 4'h0, '0, 1'b1, 4'($random(seed)), a, $random(seed), 4'($random(seed)));
      end
    end
    wait_drain();
    stall_en <= 1'b0;
    wait_drain();
    $display("checks done: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/axi_mem_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_assertions (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 ar_valid_i,
  input logic                 ar_ready_i,
  input logic                 aw_valid_i,
  input logic                 w_valid_i,
  input logic                 aw_ready_i,
  input logic                 w_ready_i,
  input logic                 b_valid_i,
  input axi_mem_pkg::b_chan_t b_i,
  input logic                 b_ready_i,
  input logic                 r_valid_i,
  input axi_mem_pkg::r_chan_t r_i,
  input logic                 r_ready_i,
  input logic                 busy_i
);

  logic [2:0] outstanding_q;  // Accepted requests still owed a response
  logic       idle;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(ar_valid_i & ar_ready_i)
                       + 3'(aw_valid_i & aw_ready_i)
                       - 3'(b_valid_i & b_ready_i) - 3'(r_valid_i & r_ready_i);
    end
  end

  assign idle = ~(ar_valid_i | aw_valid_i | w_valid_i | b_valid_i | r_valid_i)
                & (outstanding_q == '0);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else $error("B payload changed while stalled");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else $error("R payload changed while stalled");

  assert property (@(posedge clk_i)
    aw_ready_i == w_ready_i && (!aw_ready_i || (aw_valid_i && w_valid_i)))
    else $error("AW and W not taken as a pair");

  assert property (@(posedge clk_i) idle |-> !busy_i)  // Also holds during reset
    else $error("busy high while the bridge is idle");

endmodule

bind axi_mem_bridge axi_mem_assertions asrt_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .ar_valid_i   (ar_valid_i),
  .ar_ready_i   (ar_ready_o),
  .aw_valid_i   (aw_valid_i),
  .w_valid_i    (w_valid_i),
  .aw_ready_i   (aw_ready_o),
  .w_ready_i    (w_ready_o),
  .b_valid_i    (b_valid_o),
  .b_i          (b_o),
  .b_ready_i    (b_ready_i),
  .r_valid_i    (r_valid_o),
  .r_i          (r_o),
  .r_ready_i    (r_ready_i),
  .busy_i       (busy_o)
);

`default_nettype wire

/* bench/axi_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ar_valid_i,
  input  axi_mem_pkg::ar_chan_t ar_i,
  input  logic                  ar_ready_i,
  input  logic                  aw_valid_i,
  input  axi_mem_pkg::aw_chan_t aw_i,
  input  logic                  aw_ready_i,
  input  axi_mem_pkg::w_chan_t  w_i,
  input  logic                  b_valid_i,
  input  axi_mem_pkg::b_chan_t  b_i,
  input  logic                  b_ready_i,
  input  logic                  r_valid_i,
  input  axi_mem_pkg::r_chan_t  r_i,
  input  logic                  r_ready_i,
  output int                    errors_o,
  output int                    pending_o
);

  axi_mem_pkg::data_t   shadow [256];  // Word copy of both banks
  axi_mem_pkg::id_t     b_exp_q [$];
  axi_mem_pkg::r_chan_t r_exp_q [$];
  int                   err_cnt  = 0;
  int                   pend_cnt = 0;

  // Initial bank contents depend on the full byte address
  function automatic axi_mem_pkg::bank_data_t fill_half(input axi_mem_pkg::addr_t a);
    return {a[7:0] ^ 8'h5a, a[15:8] ^ 8'hc3};
  endfunction

  // Expected R payload for a read accepted now
  function automatic axi_mem_pkg::r_chan_t expected_read(input axi_mem_pkg::ar_chan_t ar);
    axi_mem_pkg::r_chan_t r;
    r.data = shadow[ar.addr[9:2]];
    r.id   = ar.id;
    r.resp = axi_mem_pkg::RespOkay;
    return r;
  endfunction

  initial begin
    axi_mem_pkg::addr_t a;
    for (int i = 0; i < 256; i++) begin
      a = axi_mem_pkg::addr_t'(i * 4);
      shadow[i] = {fill_half(a + 16'd2), fill_half(a)};
    end
  end

  assign errors_o  = err_cnt;
  assign pending_o = pend_cnt;

  // Handshakes seen at the falling edge complete at the next rising edge
  always @(negedge clk_i) begin
    axi_mem_pkg::r_chan_t exp_r;
    if (rst_ni) begin
      if (aw_valid_i && aw_ready_i) begin
        for (int k = 0; k < 4; k++) begin
          if (w_i.strb[k]) shadow[aw_i.addr[9:2]][k*8 +: 8] = w_i.data[k*8 +: 8];
        end
        b_exp_q.push_back(aw_i.id);
      end
      if (ar_valid_i && ar_ready_i) r_exp_q.push_back(expected_read(ar_i));
      if (b_valid_i && b_ready_i) begin
        if (b_exp_q.size() == 0) begin
          $display("unexpected B response at %0t with no write outstanding", $time);
          err_cnt++;
        end else if (b_i.id != b_exp_q[0] || b_i.resp != axi_mem_pkg::RespOkay) begin
          $display("mismatch at %0t: B id %0h resp %0d, expected id %0h resp 0",
                   $time, b_i.id, b_i.resp, b_exp_q[0]);
          err_cnt++;
          void'(b_exp_q.pop_front());
        end else begin
          void'(b_exp_q.pop_front());
        end
      end
      if (r_valid_i && r_ready_i) begin
        if (r_exp_q.size() == 0) begin
          $display("unexpected R response at %0t with no read outstanding", $time);
          err_cnt++;
        end else begin
          exp_r = r_exp_q.pop_front();
          if (r_i != exp_r) begin
            $display("mismatch at %0t: R id %0h data %h resp %0d, expected id %0h data %h",
                     $time, r_i.id, r_i.data, r_i.resp, exp_r.id, exp_r.data);
            err_cnt++;
          end
        end
      end
      pend_cnt = b_exp_q.size() + r_exp_q.size();
    end
  end

endmodule

`default_nettype wire

/* src/axi_mem_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_bridge (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  output logic                                                  busy_o,
  input  logic                                                  ar_valid_i,
  input  axi_mem_pkg::ar_chan_t                                 ar_i,
  output logic                                                  ar_ready_o,
  input  logic                                                  aw_valid_i,
  input  axi_mem_pkg::aw_chan_t                                 aw_i,
  output logic                                                  aw_ready_o,
  input  logic                                                  w_valid_i,
  input  axi_mem_pkg::w_chan_t                                  w_i,
  output logic                                                  w_ready_o,
  output logic                                                  b_valid_o,
  output axi_mem_pkg::b_chan_t                                  b_o,
  input  logic                                                  b_ready_i,
  output logic                                                  r_valid_o,
  output axi_mem_pkg::r_chan_t                                  r_o,
  input  logic                                                  r_ready_i,
  output logic                   [axi_mem_pkg::NumBanks-1:0]    bank_req_o,
  input  logic                   [axi_mem_pkg::NumBanks-1:0]    bank_gnt_i,
  output axi_mem_pkg::addr_t      [axi_mem_pkg::NumBanks-1:0]   bank_addr_o,
  output axi_mem_pkg::bank_data_t [axi_mem_pkg::NumBanks-1:0]   bank_wdata_o,
  output axi_mem_pkg::bank_strb_t [axi_mem_pkg::NumBanks-1:0]   bank_strb_o,
  output logic                   [axi_mem_pkg::NumBanks-1:0]    bank_we_o,
  input  logic                   [axi_mem_pkg::NumBanks-1:0]    bank_rvalid_i,
  input  axi_mem_pkg::bank_data_t [axi_mem_pkg::NumBanks-1:0]   bank_rdata_i
);

  axi_mem_pkg::mem_req_t arb_req;
  axi_mem_pkg::meta_t    arb_meta;
  axi_mem_pkg::meta_t    head_meta;
  axi_mem_pkg::data_t    resp_data;
  logic                  arb_valid;
  logic                  arb_ready;
  logic                  split_ready;
  logic                  meta_full;
  logic                  meta_empty;
  logic                  meta_pop;
  logic                  resp_valid;
  logic                  resp_ready;

  // Splitter and queue take each item together
  assign arb_ready = split_ready & ~meta_full;

  assign busy_o = ar_valid_i | aw_valid_i | w_valid_i | b_valid_o | r_valid_o | ~meta_empty;

  ax_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ar_valid_i  (ar_valid_i),
    .ar_i        (ar_i),
    .ar_ready_o  (ar_ready_o),
    .aw_valid_i  (aw_valid_i),
    .aw_i        (aw_i),
    .aw_ready_o  (aw_ready_o),
    .w_valid_i   (w_valid_i),
    .w_i         (w_i),
    .w_ready_o   (w_ready_o),
    .req_valid_o (arb_valid),
    .req_o       (arb_req),
    .meta_o      (arb_meta),
    .req_ready_i (arb_ready)
  );

  meta_fifo i_meta_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (arb_valid & arb_ready),
    .meta_i  (arb_meta),
    .full_o  (meta_full),
    .pop_i   (meta_pop),
    .meta_o  (head_meta),
    .empty_o (meta_empty)
  );

  mem_bank_split i_split (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (arb_valid & ~meta_full),  // Blocked while the queue is full
    .req_i         (arb_req),
    .req_ready_o   (split_ready),
    .resp_valid_o  (resp_valid),
    .resp_data_o   (resp_data),
    .resp_ready_i  (resp_ready),
    .bank_req_o    (bank_req_o),
    .bank_gnt_i    (bank_gnt_i),
    .bank_addr_o   (bank_addr_o),
    .bank_wdata_o  (bank_wdata_o),
    .bank_strb_o   (bank_strb_o),
    .bank_we_o     (bank_we_o),
    .bank_rvalid_i (bank_rvalid_i),
    .bank_rdata_i  (bank_rdata_i)
  );

  resp_router i_router (
    .resp_valid_i (resp_valid),
    .resp_data_i  (resp_data),
    .resp_ready_o (resp_ready),
    .meta_i       (head_meta),
    .meta_valid_i (~meta_empty),
    .pop_o        (meta_pop),
    .b_valid_o    (b_valid_o),
    .b_o          (b_o),
    .b_ready_i    (b_ready_i),
    .r_valid_o    (r_valid_o),
    .r_o          (r_o),
    .r_ready_i    (r_ready_i)
  );

endmodule

`default_nettype wire

/* src/resp_router.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_router (
  input  logic                 resp_valid_i,
  input  axi_mem_pkg::data_t   resp_data_i,
  output logic                 resp_ready_o,
  input  axi_mem_pkg::meta_t   meta_i,
  input  logic                 meta_valid_i,
  output logic                 pop_o,
  output logic                 b_valid_o,
  output axi_mem_pkg::b_chan_t b_o,
  input  logic                 b_ready_i,
  output logic                 r_valid_o,
  output axi_mem_pkg::r_chan_t r_o,
  input  logic                 r_ready_i
);

  logic joined;

  // Data and queue head must both be present
  assign joined = resp_valid_i & meta_valid_i;

  assign b_valid_o = joined & meta_i.write;
  assign r_valid_o = joined & ~meta_i.write;

  assign b_o.id   = meta_i.id;
  assign b_o.resp = axi_mem_pkg::RespOkay;

  assign r_o.data = resp_data_i;
  assign r_o.id   = meta_i.id;
  assign r_o.resp = axi_mem_pkg::RespOkay;

  // Completion on the selected channel frees both sides
  assign pop_o        = (b_valid_o & b_ready_i) | (r_valid_o & r_ready_i);
  assign resp_ready_o = pop_o;

endmodule

`default_nettype wire

/* src/mem_bank_split.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bank_split (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  req_valid_i,
  input  axi_mem_pkg::mem_req_t                                 req_i,
  output logic                                                  req_ready_o,
  output logic                                                  resp_valid_o,
  output axi_mem_pkg::data_t                                    resp_data_o,
  input  logic                                                  resp_ready_i,
  output logic                   [axi_mem_pkg::NumBanks-1:0]    bank_req_o,
  input  logic                   [axi_mem_pkg::NumBanks-1:0]    bank_gnt_i,
  output axi_mem_pkg::addr_t      [axi_mem_pkg::NumBanks-1:0]   bank_addr_o,
  output axi_mem_pkg::bank_data_t [axi_mem_pkg::NumBanks-1:0]   bank_wdata_o,
  output axi_mem_pkg::bank_strb_t [axi_mem_pkg::NumBanks-1:0]   bank_strb_o,
  output logic                   [axi_mem_pkg::NumBanks-1:0]    bank_we_o,
  input  logic                   [axi_mem_pkg::NumBanks-1:0]    bank_rvalid_i,
  input  axi_mem_pkg::bank_data_t [axi_mem_pkg::NumBanks-1:0]   bank_rdata_i
);

  localparam int unsigned NB = axi_mem_pkg::NumBanks;
  localparam int unsigned BW = axi_mem_pkg::BankWidth;
  localparam int unsigned BB = axi_mem_pkg::BankBytes;

  typedef struct packed {
    axi_mem_pkg::addr_t      addr;
    axi_mem_pkg::bank_data_t wdata;
    axi_mem_pkg::bank_strb_t strb;
    logic                    we;
  } bank_req_t;

  bank_req_t               [NB-1:0] req_in;
  bank_req_t               [NB-1:0] req_q;
  bank_req_t               [NB-1:0] req_out;
  axi_mem_pkg::bank_data_t [NB-1:0] resp_q;
  logic                    [NB-1:0] req_full_q;
  logic                    [NB-1:0] resp_full_q;
  logic                    [NB-1:0] pend_q;  // Granted, rvalid still due
  logic                    [NB-1:0] resp_valid;
  axi_mem_pkg::addr_t               base_addr;
  logic                             accept;
  logic                             resp_take;

  assign base_addr = req_i.addr & ~axi_mem_pkg::addr_t'(axi_mem_pkg::DataBytes - 1);

  // One access per bank at a time, so a held response is never overrun
  assign req_ready_o  = ~|req_full_q & ~|resp_full_q & ~|pend_q;
  assign accept       = req_valid_i & req_ready_o;
  assign resp_valid_o = &resp_valid;
  assign resp_take    = resp_valid_o & resp_ready_i;  // Pops all banks at once

  for (genvar i = 0; i < NB; i++) begin : gen_bank
    assign req_in[i].addr  = base_addr + axi_mem_pkg::addr_t'(i * BB);
    assign req_in[i].wdata = req_i.wdata[i*BW +: BW];
    assign req_in[i].strb  = req_i.strb[i*BB +: BB];
    assign req_in[i].we    = req_i.we;

    // Request fall-through
    assign bank_req_o[i]   = req_full_q[i] | accept;
    assign req_out[i]      = req_full_q[i] ? req_q[i] : req_in[i];
    assign bank_addr_o[i]  = req_out[i].addr;
    assign bank_wdata_o[i] = req_out[i].wdata;
    assign bank_strb_o[i]  = req_out[i].strb;
    assign bank_we_o[i]    = req_out[i].we;

    // Response fall-through
    assign resp_valid[i] = resp_full_q[i] | bank_rvalid_i[i];
    assign resp_data_o[i*BW +: BW] = resp_full_q[i] ? resp_q[i] : bank_rdata_i[i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        req_full_q[i]  <= 1'b0;
        resp_full_q[i] <= 1'b0;
        pend_q[i]      <= 1'b0;
      end else begin
        req_full_q[i]  <= bank_req_o[i] & ~bank_gnt_i[i];
        resp_full_q[i] <= resp_valid[i] & ~resp_take;
        pend_q[i]      <= (pend_q[i] & ~bank_rvalid_i[i]) | (bank_req_o[i] & bank_gnt_i[i]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (accept && !bank_gnt_i[i]) req_q[i] <= req_in[i];
      if (!resp_full_q[i] && bank_rvalid_i[i]) resp_q[i] <= bank_rdata_i[i];
    end
  end

endmodule

`default_nettype wire

/* src/meta_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module meta_fifo (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  axi_mem_pkg::meta_t meta_i,
  output logic               full_o,
  input  logic               pop_i,
  output axi_mem_pkg::meta_t meta_o,
  output logic               empty_o
);

  axi_mem_pkg::meta_t [axi_mem_pkg::MetaDepth-1:0] mem_q;

  logic [axi_mem_pkg::MetaPtrWidth-1:0] wr_ptr_q;
  logic [axi_mem_pkg::MetaPtrWidth-1:0] rd_ptr_q;
  logic [axi_mem_pkg::MetaCntWidth-1:0] cnt_q;
  logic                                 do_push;
  logic                                 do_pop;

  function automatic logic [axi_mem_pkg::MetaPtrWidth-1:0] next_ptr(
    input logic [axi_mem_pkg::MetaPtrWidth-1:0] ptr
  );
    if (ptr == axi_mem_pkg::MetaPtrWidth'(axi_mem_pkg::MetaDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (cnt_q == axi_mem_pkg::MetaCntWidth'(axi_mem_pkg::MetaDepth));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign meta_o  = mem_q[rd_ptr_q];  // Head of queue

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= meta_i;
  end

endmodule

`default_nettype wire

/* src/ax_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ax_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ar_valid_i,
  input  axi_mem_pkg::ar_chan_t ar_i,
  output logic                  ar_ready_o,
  input  logic                  aw_valid_i,
  input  axi_mem_pkg::aw_chan_t aw_i,
  output logic                  aw_ready_o,
  input  logic                  w_valid_i,
  input  axi_mem_pkg::w_chan_t  w_i,
  output logic                  w_ready_o,
  output logic                  req_valid_o,
  output axi_mem_pkg::mem_req_t req_o,
  output axi_mem_pkg::meta_t    meta_o,
  input  logic                  req_ready_i
);

  logic rd_pend;
  logic wr_pend;
  logic grant_rd;
  logic grant_wr;
  logic prio_wr_q;  // Write wins the next tie

  // A write needs address and data together
  assign rd_pend = ar_valid_i;
  assign wr_pend = aw_valid_i & w_valid_i;

  assign grant_wr = wr_pend & (~rd_pend | prio_wr_q);
  assign grant_rd = rd_pend & ~grant_wr;

  assign req_valid_o = rd_pend | wr_pend;
  assign ar_ready_o  = grant_rd & req_ready_i;
  assign aw_ready_o  = grant_wr & req_ready_i;
  assign w_ready_o   = grant_wr & req_ready_i;  // AW and W move as a pair

  assign req_o.addr  = grant_wr ? aw_i.addr : ar_i.addr;
  assign req_o.wdata = w_i.data;
  assign req_o.strb  = grant_wr ? w_i.strb : '0;  // Reads touch no bytes
  assign req_o.we    = grant_wr;

  assign meta_o.id    = grant_wr ? aw_i.id : ar_i.id;
  assign meta_o.write = grant_wr;

  // Hand priority to the other channel after each grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_wr_q <= 1'b0;
    end else if (req_valid_o && req_ready_i) begin
      prio_wr_q <= grant_rd;
    end
  end

endmodule

`default_nettype wire

/* src/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned NumBanks  = 2;

  localparam int unsigned BankWidth = DataWidth / NumBanks;
  localparam int unsigned DataBytes = DataWidth / 8;
  localparam int unsigned BankBytes = BankWidth / 8;

  localparam int unsigned MetaDepth    = 2;  // Accesses in flight
  localparam int unsigned MetaPtrWidth = (MetaDepth > 1) ? $clog2(MetaDepth) : 1;
  localparam int unsigned MetaCntWidth = $clog2(MetaDepth + 1);

  typedef logic [AddrWidth-1:0] addr_t;  // Byte address
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [DataBytes-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [BankWidth-1:0] bank_data_t;
  typedef logic [BankBytes-1:0] bank_strb_t;
  typedef logic [1:0]           resp_t;

  localparam resp_t RespOkay = 2'b00;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    resp_t resp;
  } r_chan_t;

  // Full-width access handed to the bank splitter
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    id_t  id;
    logic write;  // Selects B over R
  } meta_t;

endpackage

`default_nettype wire
